// File: flist.f
+incdir+hdl
hdl/mips_pkg.sv
hdl/inst_decode.sv
hdl/regfile.sv
hdl/alu_unit.sv
hdl/hilo_unit.sv
hdl/writeback_sel.sv
hdl/mips_core.sv
tests/tb_mips_core.sv

// File: Bender.yml
package:
  name: mips_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mips_pkg.sv
      - hdl/inst_decode.sv
      - hdl/regfile.sv
      - hdl/alu_unit.sv
      - hdl/hilo_unit.sv
      - hdl/writeback_sel.sv
      - hdl/mips_core.sv
  - target: test
    files:
      - tests/tb_mips_core.sv

// File: tests/tb_mips_core.sv
`timescale 1ns/100ps

module tb_mips_core;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_INSTS    = 2000;
    localparam int MAX_CYCLES   = RESET_CYCLES + NUM_INSTS + 50;

    // kept R-type functs and I-type opcodes, picked at random
    localparam logic [17*6-1:0] R_FUNCTS = {6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
                                            6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03, 6'h18,
                                            6'h19, 6'h10, 6'h12, 6'h11, 6'h13};
    localparam logic [6*6-1:0]  I_OPCODES = {6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

    logic                clk;
    logic                reset_i;
    logic                inst_valid_i;
    mips_pkg::word_t     inst_i;
    logic                wb_wen_o;
    mips_pkg::reg_addr_t wb_num_o;
    mips_pkg::word_t     wb_data_o;

    mips_pkg::word_t model_regs [32];
    mips_pkg::word_t model_hi;
    mips_pkg::word_t model_lo;
    logic [37:0]     exp_q [$];  // {wen, num, data} per cycle
    int              errors;
    int              checks;
    int              cycle_cnt = 0;

    mips_core UUT (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_wen_o     (wb_wen_o),
        .wb_num_o     (wb_num_o),
        .wb_data_o    (wb_data_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic mips_pkg::word_t random_inst();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [5:0]  fn;
        int unsigned pick;
        rs   = 5'($urandom % 8);  // small pool for frequent hazards
        rt   = 5'($urandom % 8);
        rd   = 5'($urandom % 8);
        sa   = 5'($urandom);
        pick = $urandom % 100;
        if (pick < 5)
            return {6'h00, 20'($urandom), 6'h3f};  // unused funct
        if (pick < 10)
            return {6'h3f, 26'($urandom)};  // unused opcode
        if (pick < 60) begin
            fn = R_FUNCTS[($urandom % 17) * 6 +: 6];
            if (fn > 6'h03)
                sa = '0;
            return {6'h00, rs, rt, rd, sa, fn};
        end
        return {I_OPCODES[($urandom % 6) * 6 +: 6], rs, rt, 16'($urandom)};
    endfunction

    // in-order reference model, returns the expected register write
    function automatic logic [37:0] execute(input mips_pkg::word_t inst);
        logic [5:0]      op;
        logic [5:0]      fn;
        logic [4:0]      sa;
        logic [4:0]      dest;
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t simm;
        mips_pkg::word_t zimm;
        mips_pkg::word_t res;
        logic [63:0]     uprod;
        logic            wr;
        op    = inst[31:26];
        fn    = inst[5:0];
        sa    = inst[10:6];
        a     = model_regs[inst[25:21]];
        b     = model_regs[inst[20:16]];
        simm  = {{16{inst[15]}}, inst[15:0]};
        zimm  = {16'h0000, inst[15:0]};
        dest  = (op == 6'h00) ? inst[15:11] : inst[20:16];
        uprod = {32'h0, a} * {32'h0, b};
        wr    = 1'b1;
        res   = '0;
        if (op == 6'h00) begin
            case (fn)
                6'h00: res = b << sa;
                6'h02: res = b >> sa;
                6'h03: res = (b >> sa) | (b[31] ? ~(32'hffff_ffff >> sa) : 32'h0);
                6'h21: res = a + b;
                6'h23: res = a - b;
                6'h24: res = a & b;
                6'h25: res = a | b;
                6'h26: res = a ^ b;
                6'h27: res = ~(a | b);
                6'h2a: res = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'h1 : 32'h0;
                6'h2b: res = (a < b) ? 32'h1 : 32'h0;
                6'h10: res = model_hi;
                6'h12: res = model_lo;
                6'h11: begin
                    model_hi = a;
                    wr       = 1'b0;
                end
                6'h13: begin
                    model_lo = a;
                    wr       = 1'b0;
                end
                6'h18: begin
                    // signed high half from the unsigned product
                    model_hi = uprod[63:32] - (a[31] ? b : 32'h0) - (b[31] ? a : 32'h0);
                    model_lo = uprod[31:0];
                    wr       = 1'b0;
                end
                6'h19: begin
                    model_hi = uprod[63:32];
                    model_lo = uprod[31:0];
                    wr       = 1'b0;
                end
                default: wr = 1'b0;
            endcase
        end else begin
            case (op)
                6'h09: res = a + simm;
                6'h0a: res = ((a ^ 32'h8000_0000) < (simm ^ 32'h8000_0000)) ? 32'h1 : 32'h0;
                6'h0c: res = a & zimm;
                6'h0d: res = a | zimm;
                6'h0e: res = a ^ zimm;
                6'h0f: res = {inst[15:0], 16'h0000};
                default: wr = 1'b0;
            endcase
        end
        if (dest == 5'd0)
            wr = 1'b0;
        if (wr)
            model_regs[dest] = res;
        return {wr, dest, res};
    endfunction

    task automatic check_outputs(input logic [37:0] exp);
        checks++;
        assert (wb_wen_o === exp[37]) else begin
            errors++;
            $display("[FAIL] wb_wen_o expected %h actual %h", exp[37], wb_wen_o);
        end
        if (exp[37]) begin
            assert (wb_num_o === exp[36:32]) else begin
                errors++;
                $display("[FAIL] wb_num_o expected %h actual %h", exp[36:32], wb_num_o);
            end
            assert (wb_data_o === exp[31:0]) else begin
                errors++;
                $display("[FAIL] wb_data_o expected %h actual %h", exp[31:0], wb_data_o);
            end
        end
    endtask

    initial begin
        mips_pkg::word_t inst;
        clk          = 1'b0;
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        errors       = 0;
        checks       = 0;
        void'($urandom(32'hb4e0_121d));
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_hi = '0;
        model_lo = '0;
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            #1;
            check_outputs(38'h0);  // no write while in reset
        end
        exp_q.push_back(38'h0);  // ex and wb stages empty after reset
        exp_q.push_back(38'h0);
        for (int n = 0; n < NUM_INSTS + 2; n++) begin
            @(posedge clk);
            #1;
            reset_i = 1'b0;
            check_outputs(exp_q.pop_front());
            if (n < NUM_INSTS && ($urandom % 100) >= 20) begin
                inst         = random_inst();
                inst_valid_i = 1'b1;
                inst_i       = inst;
                exp_q.push_back(execute(inst));
            end else begin
                inst_valid_i = 1'b0;
                inst_i       = $urandom;  // junk that must be ignored
                exp_q.push_back(38'h0);
            end
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: hdl/mips_core.sv
`timescale 1ns/100ps

`include "mips_defs.svh"

module mips_core (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                inst_valid_i,
    input  mips_pkg::word_t     inst_i,
    output logic                wb_wen_o,
    output mips_pkg::reg_addr_t wb_num_o,
    output mips_pkg::word_t     wb_data_o
);

    mips_pkg::reg_addr_t      rs_addr;
    mips_pkg::reg_addr_t      rt_addr;
    mips_pkg::word_t          rs_data;
    mips_pkg::word_t          rt_data;
    logic                     ex_valid;
    mips_pkg::alu_op_e        ex_alu_op;
    mips_pkg::hilo_op_e       ex_hilo_op;
    mips_pkg::word_t          ex_opa;
    mips_pkg::word_t          ex_opb;
    logic [`MIPS_SHAMT_W-1:0] ex_shamt;
    mips_pkg::reg_addr_t      ex_dest;
    logic                     ex_wen;
    mips_pkg::word_t          alu_result;
    mips_pkg::word_t          hilo_result;
    logic                     ex_fwd_wen;
    mips_pkg::reg_addr_t      ex_fwd_num;
    mips_pkg::word_t          ex_fwd_data;

    inst_decode u_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .rs_addr_o     (rs_addr),
        .rt_addr_o     (rt_addr),
        .rs_data_i     (rs_data),
        .rt_data_i     (rt_data),
        .ex_fwd_wen_i  (ex_fwd_wen),
        .ex_fwd_num_i  (ex_fwd_num),
        .ex_fwd_data_i (ex_fwd_data),
        .wb_fwd_wen_i  (wb_wen_o),   // wb stage, not yet in regfile
        .wb_fwd_num_i  (wb_num_o),
        .wb_fwd_data_i (wb_data_o),
        .ex_valid_o    (ex_valid),
        .ex_alu_op_o   (ex_alu_op),
        .ex_hilo_op_o  (ex_hilo_op),
        .ex_opa_o      (ex_opa),
        .ex_opb_o      (ex_opb),
        .ex_shamt_o    (ex_shamt),
        .ex_dest_o     (ex_dest),
        .ex_wen_o      (ex_wen)
    );

    regfile u_regfile (
        .clk       (clk),
        .reset_i   (reset_i),
        .wen_i     (wb_wen_o),
        .waddr_i   (wb_num_o),
        .wdata_i   (wb_data_o),
        .raddr_a_i (rs_addr),
        .rdata_a_o (rs_data),
        .raddr_b_i (rt_addr),
        .rdata_b_o (rt_data)
    );

    alu_unit u_alu (
        .op_i     (ex_alu_op),
        .opa_i    (ex_opa),
        .opb_i    (ex_opb),
        .shamt_i  (ex_shamt),
        .result_o (alu_result)
    );

    hilo_unit u_hilo (
        .clk      (clk),
        .reset_i  (reset_i),
        .valid_i  (ex_valid),
        .op_i     (ex_hilo_op),
        .opa_i    (ex_opa),
        .opb_i    (ex_opb),
        .result_o (hilo_result)
    );

    writeback_sel u_wb (
        .clk           (clk),
        .reset_i       (reset_i),
        .valid_i       (ex_valid),
        .hilo_op_i     (ex_hilo_op),
        .dest_i        (ex_dest),
        .wen_i         (ex_wen),
        .alu_result_i  (alu_result),
        .hilo_result_i (hilo_result),
        .ex_fwd_wen_o  (ex_fwd_wen),
        .ex_fwd_num_o  (ex_fwd_num),
        .ex_fwd_data_o (ex_fwd_data),
        .wb_wen_o      (wb_wen_o),
        .wb_num_o      (wb_num_o),
        .wb_data_o     (wb_data_o)
    );

endmodule

// File: hdl/writeback_sel.sv
`timescale 1ns/100ps

module writeback_sel (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                valid_i,
    input  mips_pkg::hilo_op_e  hilo_op_i,
    input  mips_pkg::reg_addr_t dest_i,
    input  logic                wen_i,
    input  mips_pkg::word_t     alu_result_i,
    input  mips_pkg::word_t     hilo_result_i,
    output logic                ex_fwd_wen_o,
    output mips_pkg::reg_addr_t ex_fwd_num_o,
    output mips_pkg::word_t     ex_fwd_data_o,
    output logic                wb_wen_o,
    output mips_pkg::reg_addr_t wb_num_o,
    output mips_pkg::word_t     wb_data_o
);

    logic from_hilo;

    assign from_hilo = (hilo_op_i == mips_pkg::HILO_MFHI) ||
                       (hilo_op_i == mips_pkg::HILO_MFLO);

    assign ex_fwd_wen_o  = valid_i && wen_i;
    assign ex_fwd_num_o  = dest_i;
    assign ex_fwd_data_o = from_hilo ? hilo_result_i : alu_result_i;

    always_ff @(posedge clk) begin
        if (reset_i)
            wb_wen_o <= 1'b0;
        else
            wb_wen_o <= ex_fwd_wen_o;
    end

    always_ff @(posedge clk) begin
        wb_num_o  <= ex_fwd_num_o;
        wb_data_o <= ex_fwd_data_o;
    end

endmodule

// File: hdl/hilo_unit.sv
`timescale 1ns/100ps

`include "mips_defs.svh"

module hilo_unit (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               valid_i,
    input  mips_pkg::hilo_op_e op_i,
    input  mips_pkg::word_t    opa_i,
    input  mips_pkg::word_t    opb_i,
    output mips_pkg::word_t    result_o
);

    mips_pkg::word_t               hi;
    mips_pkg::word_t               lo;
    logic signed [2*`MIPS_DATA_W-1:0] prod_s;
    logic [2*`MIPS_DATA_W-1:0]        prod_u;

    // operands widen to 64 bits before the multiply
    assign prod_s = $signed(opa_i) * $signed(opb_i);
    assign prod_u = opa_i * opb_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hi <= '0;
            lo <= '0;
        end else if (valid_i) begin
            case (op_i)
                mips_pkg::HILO_MULT: begin
                    hi <= prod_s[2*`MIPS_DATA_W-1:`MIPS_DATA_W];
                    lo <= prod_s[`MIPS_DATA_W-1:0];
                end
                mips_pkg::HILO_MULTU: begin
                    hi <= prod_u[2*`MIPS_DATA_W-1:`MIPS_DATA_W];
                    lo <= prod_u[`MIPS_DATA_W-1:0];
                end
                mips_pkg::HILO_MTHI: hi <= opa_i;
                mips_pkg::HILO_MTLO: lo <= opa_i;
                default: ;  // reads leave hi/lo alone
            endcase
        end
    end

    // current register value, a multiply just before is already in
    always_comb begin
        case (op_i)
            mips_pkg::HILO_MFHI: result_o = hi;
            mips_pkg::HILO_MFLO: result_o = lo;
            default:             result_o = '0;
        endcase
    end

endmodule

// File: hdl/alu_unit.sv
`timescale 1ns/100ps

`include "mips_defs.svh"

module alu_unit (
    input  mips_pkg::alu_op_e        op_i,
    input  mips_pkg::word_t          opa_i,
    input  mips_pkg::word_t          opb_i,
    input  logic [`MIPS_SHAMT_W-1:0] shamt_i,
    output mips_pkg::word_t          result_o
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(opa_i) < $signed(opb_i);
    assign lt_unsigned = opa_i < opb_i;

    always_comb begin
        case (op_i)
            mips_pkg::ALU_ADDU: result_o = opa_i + opb_i;
            mips_pkg::ALU_SUBU: result_o = opa_i - opb_i;
            mips_pkg::ALU_AND:  result_o = opa_i & opb_i;
            mips_pkg::ALU_OR:   result_o = opa_i | opb_i;
            mips_pkg::ALU_XOR:  result_o = opa_i ^ opb_i;
            mips_pkg::ALU_NOR:  result_o = ~(opa_i | opb_i);
            mips_pkg::ALU_SLT: begin
                result_o = {{(`MIPS_DATA_W-1){1'b0}}, lt_signed};
            end
            mips_pkg::ALU_SLTU: begin
                result_o = {{(`MIPS_DATA_W-1){1'b0}}, lt_unsigned};
            end
            mips_pkg::ALU_SLL:  result_o = opb_i << shamt_i;
            mips_pkg::ALU_SRL:  result_o = opb_i >> shamt_i;
            mips_pkg::ALU_SRA:  result_o = $signed(opb_i) >>> shamt_i;  // sign fill
            mips_pkg::ALU_LUI: begin
                result_o = {opb_i[`MIPS_IMM_W-1:0], {(`MIPS_DATA_W-`MIPS_IMM_W){1'b0}}};
            end
            default:            result_o = '0;
        endcase
    end

endmodule

// File: hdl/regfile.sv
`timescale 1ns/100ps

`include "mips_defs.svh"

module regfile (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                wen_i,
    input  mips_pkg::reg_addr_t waddr_i,
    input  mips_pkg::word_t     wdata_i,
    input  mips_pkg::reg_addr_t raddr_a_i,
    output mips_pkg::word_t     rdata_a_o,
    input  mips_pkg::reg_addr_t raddr_b_i,
    output mips_pkg::word_t     rdata_b_o
);

    mips_pkg::word_t regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 reads as zero
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// File: hdl/inst_decode.sv
`timescale 1ns/100ps

`include "mips_defs.svh"

module inst_decode (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     inst_valid_i,
    input  mips_pkg::word_t          inst_i,
    output mips_pkg::reg_addr_t      rs_addr_o,
    output mips_pkg::reg_addr_t      rt_addr_o,
    input  mips_pkg::word_t          rs_data_i,
    input  mips_pkg::word_t          rt_data_i,
    input  logic                     ex_fwd_wen_i,
    input  mips_pkg::reg_addr_t      ex_fwd_num_i,
    input  mips_pkg::word_t          ex_fwd_data_i,
    input  logic                     wb_fwd_wen_i,
    input  mips_pkg::reg_addr_t      wb_fwd_num_i,
    input  mips_pkg::word_t          wb_fwd_data_i,
    output logic                     ex_valid_o,
    output mips_pkg::alu_op_e        ex_alu_op_o,
    output mips_pkg::hilo_op_e       ex_hilo_op_o,
    output mips_pkg::word_t          ex_opa_o,
    output mips_pkg::word_t          ex_opb_o,
    output logic [`MIPS_SHAMT_W-1:0] ex_shamt_o,
    output mips_pkg::reg_addr_t      ex_dest_o,
    output logic                     ex_wen_o
);

    logic [`MIPS_OPC_W-1:0] opcode;
    logic [`MIPS_OPC_W-1:0] funct;
    logic [`MIPS_IMM_W-1:0] imm;
    mips_pkg::reg_addr_t    rd_addr;
    mips_pkg::reg_addr_t    dest;
    mips_pkg::alu_op_e      alu_op;
    mips_pkg::hilo_op_e     hilo_op;
    logic                   is_rtype;
    logic                   zero_ext;
    logic                   writes;
    mips_pkg::word_t        rs_val;
    mips_pkg::word_t        rt_val;
    mips_pkg::word_t        imm_ext;

    // execute stage wins over writeback, then the register file
    function automatic mips_pkg::word_t fwd(input mips_pkg::reg_addr_t addr,
                                            input mips_pkg::word_t rf_data);
        mips_pkg::word_t val;
        val = rf_data;
        if (wb_fwd_wen_i && wb_fwd_num_i == addr)
            val = wb_fwd_data_i;
        if (ex_fwd_wen_i && ex_fwd_num_i == addr)
            val = ex_fwd_data_i;
        return val;
    endfunction

    assign opcode    = inst_i[`MIPS_OPC_POS +: `MIPS_OPC_W];
    assign funct     = inst_i[`MIPS_FUNCT_POS +: `MIPS_OPC_W];
    assign imm       = inst_i[`MIPS_IMM_POS +: `MIPS_IMM_W];
    assign rs_addr_o = inst_i[`MIPS_RS_POS +: `MIPS_REG_ADDR_W];
    assign rt_addr_o = inst_i[`MIPS_RT_POS +: `MIPS_REG_ADDR_W];
    assign rd_addr   = inst_i[`MIPS_RD_POS +: `MIPS_REG_ADDR_W];
    assign is_rtype  = (opcode == '0);

    always_comb begin
        alu_op   = mips_pkg::ALU_NOP;
        hilo_op  = mips_pkg::HILO_NOP;
        zero_ext = 1'b0;
        if (is_rtype) begin
            case (funct)
                6'h00: alu_op = mips_pkg::ALU_SLL;
                6'h02: alu_op = mips_pkg::ALU_SRL;
                6'h03: alu_op = mips_pkg::ALU_SRA;
                6'h10: hilo_op = mips_pkg::HILO_MFHI;
                6'h11: hilo_op = mips_pkg::HILO_MTHI;
                6'h12: hilo_op = mips_pkg::HILO_MFLO;
                6'h13: hilo_op = mips_pkg::HILO_MTLO;
                6'h18: hilo_op = mips_pkg::HILO_MULT;
                6'h19: hilo_op = mips_pkg::HILO_MULTU;
                6'h21: alu_op = mips_pkg::ALU_ADDU;
                6'h23: alu_op = mips_pkg::ALU_SUBU;
                6'h24: alu_op = mips_pkg::ALU_AND;
                6'h25: alu_op = mips_pkg::ALU_OR;
                6'h26: alu_op = mips_pkg::ALU_XOR;
                6'h27: alu_op = mips_pkg::ALU_NOR;
                6'h2a: alu_op = mips_pkg::ALU_SLT;
                6'h2b: alu_op = mips_pkg::ALU_SLTU;
                default: ;  // unsupported funct, no-op
            endcase
        end else begin
            zero_ext = (opcode >= 6'h0c);  // andi, ori, xori, lui
            case (opcode)
                6'h09: alu_op = mips_pkg::ALU_ADDU;  // addiu
                6'h0a: alu_op = mips_pkg::ALU_SLT;   // slti
                6'h0c: alu_op = mips_pkg::ALU_AND;
                6'h0d: alu_op = mips_pkg::ALU_OR;
                6'h0e: alu_op = mips_pkg::ALU_XOR;
                6'h0f: alu_op = mips_pkg::ALU_LUI;
                default: ;
            endcase
        end
    end

    assign writes = (alu_op != mips_pkg::ALU_NOP) ||
                    (hilo_op == mips_pkg::HILO_MFHI) ||
                    (hilo_op == mips_pkg::HILO_MFLO);
    assign dest    = is_rtype ? rd_addr : rt_addr_o;
    assign imm_ext = zero_ext ? {{(`MIPS_DATA_W-`MIPS_IMM_W){1'b0}}, imm} :
                                {{(`MIPS_DATA_W-`MIPS_IMM_W){imm[`MIPS_IMM_W-1]}}, imm};

    always_comb begin
        rs_val = fwd(rs_addr_o, rs_data_i);
        rt_val = fwd(rt_addr_o, rt_data_i);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_valid_o   <= 1'b0;
            ex_alu_op_o  <= mips_pkg::ALU_NOP;
            ex_hilo_op_o <= mips_pkg::HILO_NOP;
            ex_wen_o     <= 1'b0;
        end else begin
            ex_valid_o   <= inst_valid_i;
            ex_alu_op_o  <= alu_op;
            ex_hilo_op_o <= hilo_op;
            ex_wen_o     <= writes && (dest != '0);  // r0 never written
        end
    end

    always_ff @(posedge clk) begin
        ex_opa_o   <= rs_val;
        ex_opb_o   <= is_rtype ? rt_val : imm_ext;
        ex_shamt_o <= inst_i[`MIPS_SHAMT_POS +: `MIPS_SHAMT_W];
        ex_dest_o  <= dest;
    end

endmodule

// File: hdl/mips_pkg.sv
`include "mips_defs.svh"

package mips_pkg;

    typedef logic [`MIPS_DATA_W-1:0]     word_t;
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADDU,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        HILO_NOP,
        HILO_MULT,
        HILO_MULTU,
        HILO_MFHI,
        HILO_MFLO,
        HILO_MTHI,
        HILO_MTLO
    } hilo_op_e;

endpackage

// File: hdl/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define MIPS_DATA_W      32
`define MIPS_REG_ADDR_W  5
`define MIPS_NUM_REGS    32

// lsb positions of the instruction fields
`define MIPS_OPC_POS     26
`define MIPS_RS_POS      21
`define MIPS_RT_POS      16
`define MIPS_RD_POS      11
`define MIPS_SHAMT_POS   6
`define MIPS_FUNCT_POS   0
`define MIPS_IMM_POS     0

`define MIPS_OPC_W       6  // opcode and funct
`define MIPS_SHAMT_W     5
`define MIPS_IMM_W       16

`endif
